/* hdl/bpu_pkg.sv */
package bpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;  // pc and targets
    typedef logic [XLEN-1:0] inst_t;
    typedef logic [1:0]      ctr_t;   // 2-bit saturating counter

    // bimodal direction table, indexed by pc[6:1]
    localparam int   BM_ENTRIES = 64;
    localparam int   BM_IDX_W   = 6;
    localparam ctr_t CTR_INIT   = 2'd1;  // weakly not taken
    typedef logic [BM_IDX_W-1:0] bm_idx_t;

    // btb: index pc[5:2], tag pc[31:6]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    localparam int BTB_TAG_W   = 26;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // return address stack, pointer counts 0..RAS_DEPTH
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 4;
    typedef logic [RAS_PTR_W-1:0] ras_ptr_t;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  is_ret;
        addr_t br_off;   // sign-extended B-type offset
        addr_t jal_off;  // sign-extended J-type offset
    } decode_t;

    // resolved control transfer from EX
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
        addr_t target;
        inst_t inst;
    } update_t;

    typedef struct packed {
        logic  is_ctrl;
        logic  taken;
        addr_t target;
    } pred_t;

endpackage

/* hdl/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import bpu_pkg::*; (
    input  inst_t   inst_i,
    output decode_t dec_o
);

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic       is_jalr;
    logic       rs1_link;

    assign opcode = inst_i[6:0];
    assign rs1    = inst_i[19:15];

    // x1 (ra) or x5 (t0) are the link registers
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);
    assign is_jalr  = (opcode == OP_JALR);

    assign dec_o.is_branch = (opcode == OP_BRANCH);
    assign dec_o.is_jal    = (opcode == OP_JAL);
    assign dec_o.is_jalr   = is_jalr;
    assign dec_o.is_ret    = is_jalr && rs1_link;  // same rule on fetch and EX side

    // B-type: imm[12|10:5|4:1|11]
    assign dec_o.br_off = {
        {20{inst_i[31]}},
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // J-type: imm[20|10:1|11|19:12]
    assign dec_o.jal_off = {
        {12{inst_i[31]}},
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

endmodule

/* hdl/bimodal_table.sv */
`timescale 1ns/1ps

module bimodal_table import bpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   rd_pc_i,
    output ctr_t    ctr_o,
    input  update_t upd_i
);

    ctr_t    ctr_q [BM_ENTRIES];
    bm_idx_t rd_idx;
    bm_idx_t upd_idx;
    ctr_t    upd_ctr;

    // halfword aligned index, bit 0 is always zero
    assign rd_idx  = rd_pc_i[BM_IDX_W:1];
    assign upd_idx = upd_i.pc[BM_IDX_W:1];

    assign ctr_o   = ctr_q[rd_idx];  // same-cycle read
    assign upd_ctr = ctr_q[upd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BM_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (upd_i.valid) begin
            if (upd_i.taken) begin
                if (upd_ctr != 2'd3) begin  // saturate at strongly taken
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'd0) begin
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

/* hdl/btb.sv */
`timescale 1ns/1ps

module btb import bpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   look_pc_i,
    output logic    hit_o,
    output addr_t   target_o,
    input  update_t upd_i
);

    btb_tag_t                tag_q    [BTB_ENTRIES];
    addr_t                   target_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]  valid_q;

    btb_idx_t look_idx;
    btb_tag_t look_tag;
    btb_idx_t upd_idx;
    btb_tag_t upd_tag;
    logic     upd_we;

    assign look_idx = look_pc_i[BTB_IDX_W+1:2];
    assign look_tag = look_pc_i[XLEN-1:XLEN-BTB_TAG_W];
    assign upd_idx  = upd_i.pc[BTB_IDX_W+1:2];
    assign upd_tag  = upd_i.pc[XLEN-1:XLEN-BTB_TAG_W];

    // only taken transfers allocate, old entry is simply replaced
    assign upd_we = upd_i.valid && upd_i.taken;

    assign hit_o    = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
    assign target_o = target_q[look_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_we) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_we) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_i.target;
        end
    end

    // invalid entries must mask the uninitialised tag array
    hit_known_a: assert property (@(posedge clk) disable iff (rst) !$isunknown(hit_o));

endmodule

/* hdl/ras_stack.sv */
`timescale 1ns/1ps

module ras_stack import bpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    push_i,
    input  addr_t   push_addr_i,
    input  logic    ex_is_ret_i,
    input  update_t upd_i,
    input  logic    stall_i,
    output logic    nonempty_o,
    output addr_t   top_o
);

    addr_t    stack_q [RAS_DEPTH];
    ras_ptr_t sp_q;       // next free slot
    ras_ptr_t sp_pop;     // pointer after a possible pop
    ras_ptr_t top_idx;
    logic     do_pop;
    logic     do_push;

    // pop on a resolved taken return
    assign do_pop = upd_i.valid && upd_i.taken && ex_is_ret_i && !stall_i
                    && (sp_q != '0);

    assign sp_pop = do_pop ? sp_q - 1'b1 : sp_q;

    // push lands on the slot freed by a same-cycle pop
    assign do_push = push_i && !stall_i && (sp_pop != ras_ptr_t'(RAS_DEPTH));

    assign top_idx    = sp_q - 1'b1;  // garbage when empty, masked by nonempty_o
    assign nonempty_o = (sp_q != '0);
    assign top_o      = stack_q[top_idx[RAS_PTR_W-2:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_push) begin
            sp_q <= sp_pop + 1'b1;
        end else begin
            sp_q <= sp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_pop[RAS_PTR_W-2:0]] <= push_addr_i;
        end
    end

    // full stack drops pushes, pointer never runs past depth
    sp_bound_a: assert property (
        @(posedge clk) disable iff (rst) sp_q <= ras_ptr_t'(RAS_DEPTH)
    );

endmodule

/* hdl/pred_select.sv */
`timescale 1ns/1ps

module pred_select import bpu_pkg::*; (
    input  addr_t   pc_i,
    input  decode_t dec_i,
    input  ctr_t    ctr_i,
    input  logic    btb_hit_i,
    input  addr_t   btb_target_i,
    input  logic    ras_nonempty_i,
    input  addr_t   ras_top_i,
    output pred_t   pred_o
);

    addr_t seq_pc;
    addr_t br_target;
    addr_t jal_target;

    assign seq_pc     = pc_i + addr_t'(4);
    assign br_target  = pc_i + dec_i.br_off;
    assign jal_target = pc_i + dec_i.jal_off;

    always_comb begin
        pred_o.is_ctrl = 1'b0;
        pred_o.taken   = 1'b0;
        pred_o.target  = seq_pc;
        if (dec_i.is_ret) begin
            // empty stack falls through to pc+4
            if (ras_nonempty_i) begin
                pred_o.is_ctrl = 1'b1;
                pred_o.taken   = 1'b1;
                pred_o.target  = ras_top_i;
            end
        end else if (dec_i.is_jal) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = 1'b1;
            pred_o.target  = btb_hit_i ? btb_target_i : jal_target;
        end else if (dec_i.is_branch || dec_i.is_jalr) begin
            pred_o.is_ctrl = 1'b1;
            if (ctr_i[1]) begin  // upper bit gives direction
                pred_o.taken = 1'b1;
                if (btb_hit_i) begin
                    pred_o.target = btb_target_i;
                end else if (dec_i.is_branch) begin
                    pred_o.target = br_target;
                end
            end
        end
    end

    always_comb begin
        assert #0 (!pred_o.taken || pred_o.is_ctrl)
            else $error("taken prediction on a non-control instruction");
    end

endmodule

/* hdl/bpu.sv */
`timescale 1ns/1ps

module bpu import bpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   if_pc_i,
    input  inst_t   if_inst_i,
    input  update_t ex_upd_i,
    input  logic    ras_push_i,
    input  addr_t   ras_push_addr_i,
    input  logic    stall_i,
    output pred_t   pred_o
);

    decode_t if_dec;
    decode_t ex_dec;
    ctr_t    bm_ctr;
    logic    btb_hit;
    addr_t   btb_target;
    logic    ras_nonempty;
    addr_t   ras_top;

    // fetch side
    inst_decode if_decode_inst (.inst_i(if_inst_i), .dec_o(if_dec));

    // EX side, only is_ret is needed
    inst_decode ex_decode_inst (.inst_i(ex_upd_i.inst), .dec_o(ex_dec));

    bimodal_table bimodal_inst (
        .clk(clk), .rst(rst),
        .rd_pc_i(if_pc_i), .ctr_o(bm_ctr), .upd_i(ex_upd_i)
    );

    btb btb_inst (
        .clk(clk), .rst(rst),
        .look_pc_i(if_pc_i), .hit_o(btb_hit), .target_o(btb_target),
        .upd_i(ex_upd_i)
    );

    ras_stack ras_inst (
        .clk(clk), .rst(rst),
        .push_i(ras_push_i), .push_addr_i(ras_push_addr_i),
        .ex_is_ret_i(ex_dec.is_ret), .upd_i(ex_upd_i), .stall_i(stall_i),
        .nonempty_o(ras_nonempty), .top_o(ras_top)
    );

    pred_select select_inst (
        .pc_i(if_pc_i), .dec_i(if_dec), .ctr_i(bm_ctr),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_nonempty_i(ras_nonempty), .ras_top_i(ras_top),
        .pred_o(pred_o)
    );

endmodule

/* include/bpu_model.svh */
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// shadow state of the predictor tables
ctr_t     m_ctr        [BM_ENTRIES];
btb_tag_t m_btb_tag    [BTB_ENTRIES];
addr_t    m_btb_target [BTB_ENTRIES];
logic     m_btb_valid  [BTB_ENTRIES];
addr_t    m_ras        [RAS_DEPTH];
int       m_sp;

function automatic void model_reset();
    for (int i = 0; i < BM_ENTRIES; i++) begin
        m_ctr[i] = CTR_INIT;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
    end
    m_sp = 0;
endfunction

function automatic logic model_is_ret(inst_t inst);
    return (inst[6:0] == OP_JALR) && (inst[19:15] == 5'd1 || inst[19:15] == 5'd5);
endfunction

function automatic pred_t model_predict(addr_t pc, inst_t inst);
    pred_t      p;
    logic [6:0] op;
    int         bi;
    int         ti;
    logic       hit;
    addr_t      boff;
    addr_t      joff;
    op   = inst[6:0];
    bi   = pc[6:1];
    ti   = pc[5:2];
    hit  = m_btb_valid[ti] && (m_btb_tag[ti] == pc[31:6]);
    boff = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    joff = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    p = '{is_ctrl: 1'b0, taken: 1'b0, target: pc + 32'd4};
    if (model_is_ret(inst)) begin
        if (m_sp > 0) begin
            p = '{is_ctrl: 1'b1, taken: 1'b1, target: m_ras[m_sp-1]};
        end
    end else if (op == OP_JAL) begin
        p = '{is_ctrl: 1'b1, taken: 1'b1, target: hit ? m_btb_target[ti] : pc + joff};
    end else if (op == OP_BRANCH || op == OP_JALR) begin
        p.is_ctrl = 1'b1;
        if (m_ctr[bi][1]) begin
            p.taken = 1'b1;
            if (hit) p.target = m_btb_target[ti];
            else if (op == OP_BRANCH) p.target = pc + boff;
        end
    end
    return p;
endfunction

// applies one clock edge worth of updates
task automatic model_update(update_t upd, logic push, addr_t push_addr, logic stall);
    int bi;
    int ti;
    int sp;
    bi = upd.pc[6:1];
    ti = upd.pc[5:2];
    sp = m_sp;
    if (upd.valid) begin
        if (upd.taken && m_ctr[bi] != 2'd3) m_ctr[bi] = m_ctr[bi] + 2'd1;
        if (!upd.taken && m_ctr[bi] != 2'd0) m_ctr[bi] = m_ctr[bi] - 2'd1;
        if (upd.taken) begin
            m_btb_tag[ti]    = upd.pc[31:6];
            m_btb_target[ti] = upd.target;
            m_btb_valid[ti]  = 1'b1;
        end
    end
    if (!stall) begin
        if (upd.valid && upd.taken && model_is_ret(upd.inst) && sp > 0) sp--;
        if (push && sp < RAS_DEPTH) begin
            m_ras[sp] = push_addr;
            sp++;
        end
    end
    m_sp = sp;
endtask

`endif

/* test/bpu_tb.sv */
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

    localparam int NUM_CYCLES = 4000;

    logic    clk;
    logic    rst;
    addr_t   if_pc;
    inst_t   if_inst;
    update_t ex_upd;
    logic    ras_push;
    addr_t   ras_push_addr;
    logic    stall;
    pred_t   pred;

    logic [31:0] rng_state;
    addr_t       pc_pool [8];  // small pool so bimodal and btb entries alias

    `include "bpu_model.svh"

    bpu bpu_inst (
        .clk(clk), .rst(rst),
        .if_pc_i(if_pc), .if_inst_i(if_inst), .ex_upd_i(ex_upd),
        .ras_push_i(ras_push), .ras_push_addr_i(ras_push_addr),
        .stall_i(stall), .pred_o(pred)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic addr_t pick_pc();
        logic [31:0] r;
        r = xorshift();
        return pc_pool[r[2:0]];
    endfunction

    // weighted mix of control and alu instructions
    function automatic inst_t make_inst();
        logic [31:0] r;
        logic [31:0] kind;
        r    = xorshift();
        kind = xorshift() % 10;
        case (kind)
            0, 1, 2: return {r[31:7], OP_BRANCH};
            3:       return {r[31:7], OP_JAL};
            4:       return {r[31:20], r[19:17], 2'b10, r[14:7], OP_JALR};  // never x1/x5
            5, 6:    return {r[31:20], (r[18] ? 5'd5 : 5'd1), r[14:7], OP_JALR};
            default: return {r[31:7], 7'b0010011};
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        r = xorshift();
        if_pc         = pick_pc();
        if_inst       = make_inst();
        ex_upd.valid  = (r[1:0] != 2'b00);
        ex_upd.taken  = (r[3:2] != 2'b00);
        ex_upd.pc     = pick_pc();
        ex_upd.target = pick_pc() + addr_t'({r[15:8], 2'b00});
        ex_upd.inst   = make_inst();
        ras_push      = (r[18:16] == 3'b000);  // roughly balances the pop rate
        ras_push_addr = xorshift() & 32'hffff_fffc;
        stall         = (r[21:19] < 3'd2);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic check_pred(string name);
        pred_t exp;
        exp = model_predict(if_pc, if_inst);
        check_value({name, " is_ctrl"}, 32'(exp.is_ctrl), 32'(pred.is_ctrl));
        check_value({name, " taken"}, 32'(exp.taken), 32'(pred.taken));
        check_value({name, " target"}, exp.target, pred.target);
    endtask

    initial begin
        rng_state     = 32'd20674;
        pc_pool       = '{32'h0000_1000, 32'h0000_1040, 32'h0000_2000, 32'h0000_1008,
                          32'h0000_100c, 32'h0000_3004, 32'h0000_1080, 32'h0000_2048};
        rst           = 1'b1;
        if_pc         = '0;
        if_inst       = '0;
        ex_upd        = '0;
        ras_push      = 1'b0;
        ras_push_addr = '0;
        stall         = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        if_pc   = 32'h0000_1000;
        if_inst = 32'h0000_0013;  // nop
        #1;
        check_pred("nop after reset");
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk);
            drive_random();
            #1;
            check_pred($sformatf("random cycle %0d", cyc));
            model_update(ex_upd, ras_push, ras_push_addr, stall);  // edge that follows
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(NUM_CYCLES * 20);
        $display("simulation ran past its time limit");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src.f */
+incdir+include
hdl/bpu_pkg.sv
hdl/inst_decode.sv
hdl/bimodal_table.sv
hdl/btb.sv
hdl/ras_stack.sv
hdl/pred_select.sv
hdl/bpu.sv
test/bpu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := bpu_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
COMMON     := --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
